/* Bender.yml */
package:
  name: mem_transfer_demo

sources:
  # RTL in compile order
  - files:
      - verilog/memDemoPkg.sv
      - verilog/sramArray.sv
      - verilog/regFile.sv
      - verilog/transferCtrl.sv
      - verilog/memTransferDemo.sv
  # Testbench
  - target: test
    files:
      - test/memTransferChecker.sv
      - test/memTransferDemoTb.sv

/* flist.f */
verilog/memDemoPkg.sv
verilog/sramArray.sv
verilog/regFile.sv
verilog/transferCtrl.sv
verilog/memTransferDemo.sv
test/memTransferChecker.sv
test/memTransferDemoTb.sv

/* test/memTransferChecker.sv */
//##############################
// Scoreboard for the memory transfer demo
// Watches the view ports and compares each item with a reference model
// Prints one line per run and keeps the error counts
//##############################

`timescale 1ns/1ps

module memTransferChecker (
	input logic clk,
	input logic rst,
	input logic [memDemoPkg::dataWidth-1:0] expBase,
	input logic busy,
	input logic done,
	input logic viewValid,
	input logic [memDemoPkg::phaseWidth-1:0] viewPhase,
	input logic [memDemoPkg::sramAdrxWidth-1:0] viewAdrx,
	input logic [memDemoPkg::dataWidth-1:0] viewData,
	input logic [memDemoPkg::dataWidth-1:0] viewMirror,
	output int runsDone,
	output int itemCount,
	output int errorCount
);

	import memDemoPkg::*;

	// Items seen in the current run
	int readCnt;
	int dumpCnt;
	// Errors already counted when the run began
	int runErrStart;
	// Busy as sampled on the previous edge
	logic busyQ;

	// Expected {viewData, viewMirror} for flat index idx (0 to 127)
	// Readout item i of pass b has idx = 32b + i
	// Dump item k has idx = k
	function automatic logic [2*dataWidth-1:0] refItem(
		input logic [phaseWidth-1:0] ph,
		input logic [dataWidth-1:0] base,
		input int idx
	);
		int blk;
		int pos;
		logic [dataWidth-1:0] mirror;
		blk = idx / blockSize;
		pos = idx % blockSize;
		// Entry 31 minus i of the same block
		mirror = base - dataWidth'(blk * blockSize + blockSize - 1 - pos);
		if (ph == phaseReadout) begin
			return {base - dataWidth'(idx), mirror};
		end
		// Dump shows the writeback word and a zero mirror
		return {mirror, {dataWidth{1'b0}}};
	endfunction

	task automatic compareField(input string name, input logic [dataWidth-1:0] expV,
		input logic [dataWidth-1:0] actV, input int idx);
		if (actV !== expV) begin
			$display("FAILED %s run %0d phase %0d item %0d: expected %h, got %h",
				name, runsDone, viewPhase, idx, expV, actV);
			errorCount++;
		end
	endtask

	task automatic checkItem();
		logic [2*dataWidth-1:0] expItem;
		logic [dataWidth-1:0] expAdrx;
		int idx;
		itemCount++;
		if (!busy) begin
			$display("View strobe seen while busy was low in run %0d", runsDone);
			errorCount++;
		end
		if (viewPhase == phaseReadout) begin
			idx = readCnt;
			expAdrx = dataWidth'(idx % blockSize);
			readCnt++;
		end else if (viewPhase == phaseDump) begin
			idx = dumpCnt;
			expAdrx = dataWidth'(idx);
			dumpCnt++;
		end else begin
			$display("View strobe in unexpected phase %0d in run %0d", viewPhase, runsDone);
			errorCount++;
			return;
		end
		// Beyond 128 items of a phase
		if (idx >= fillCount) begin
			$display("Too many items in phase %0d of run %0d", viewPhase, runsDone);
			errorCount++;
			return;
		end
		expItem = refItem(viewPhase, expBase, idx);
		compareField("viewAdrx", expAdrx, dataWidth'(viewAdrx), idx);
		compareField("viewData", expItem[2*dataWidth-1:dataWidth], viewData, idx);
		compareField("viewMirror", expItem[dataWidth-1:0], viewMirror, idx);
	endtask

	task automatic finishRun();
		if (!busyQ) begin
			$display("Done pulsed without a run in progress");
			errorCount++;
		end
		if (readCnt != fillCount || dumpCnt != fillCount) begin
			$display("Run %0d ended with %0d readout and %0d dump items instead of %0d",
				runsDone, readCnt, dumpCnt, fillCount);
			errorCount++;
		end
		$display("Run %0d base %h: %0d readout, %0d dump items, %0d errors", runsDone,
			expBase, readCnt, dumpCnt, errorCount - runErrStart);
		runsDone++;
		readCnt = 0;
		dumpCnt = 0;
		runErrStart = errorCount;
	endtask

	// Sample on the rising edge before the DUT registers update
	always @(posedge clk) begin
		if (rst) begin
			runsDone = 0;
			itemCount = 0;
			errorCount = 0;
			readCnt = 0;
			dumpCnt = 0;
			runErrStart = 0;
		end else begin
			// Busy may only fall on the edge that raises done
			if (busyQ && !busy && !done) begin
				$display("Busy dropped before done in run %0d", runsDone);
				errorCount++;
			end
			if (viewValid) begin
				checkItem();
			end
			if (done) begin
				finishRun();
			end
		end
		busyQ = busy;
	end

endmodule

/* test/memTransferDemoTb.sv */
//##############################
// Testbench for the memory transfer demo
// Three runs, fixed base then two random bases
// Scoreboard sits in memTransferChecker
//##############################

`timescale 1ns/1ps

module memTransferDemoTb;

	import memDemoPkg::*;

	// Test constants
	localparam int seedInit = 85047;
	localparam int runCount = 3;
	localparam int resetCycles = 10;
	localparam int runBound = 700;
	localparam int cycleLimit = resetCycles + runCount * runBound;
	localparam int driveDelay = 2;
	// Stray start lands in the fill phase
	localparam int strayDelay = 50;

	logic clk;
	logic rst;
	logic start;
	logic [dataWidth-1:0] fillBase;
	logic busy;
	logic done;
	logic viewValid;
	logic [phaseWidth-1:0] viewPhase;
	logic [sramAdrxWidth-1:0] viewAdrx;
	logic [dataWidth-1:0] viewData;
	logic [dataWidth-1:0] viewMirror;

	// Base the checker expects for the current run
	logic [dataWidth-1:0] expBase;
	logic [dataWidth-1:0] runBase;
	int seed;
	int tbErrors;
	int cycleCnt = 0;
	int runsDone;
	int itemCount;
	int errorCount;

	memTransferDemo u_memTransferDemo (
		.clk(clk),
		.rst(rst),
		.start(start),
		.fillBase(fillBase),
		.busy(busy),
		.done(done),
		.viewValid(viewValid),
		.viewPhase(viewPhase),
		.viewAdrx(viewAdrx),
		.viewData(viewData),
		.viewMirror(viewMirror)
	);

	memTransferChecker u_checker (
		.clk(clk),
		.rst(rst),
		.expBase(expBase),
		.busy(busy),
		.done(done),
		.viewValid(viewValid),
		.viewPhase(viewPhase),
		.viewAdrx(viewAdrx),
		.viewData(viewData),
		.viewMirror(viewMirror),
		.runsDone(runsDone),
		.itemCount(itemCount),
		.errorCount(errorCount)
	);

	// 20 ns clock
	initial clk = 1'b0;
	always #10 clk = ~clk;

	// Run limit, three generous runs plus reset
	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= cycleLimit) begin
			$display("Timeout: done never arrived within %0d cycles", cycleLimit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Step to just after the next rising edges
	task automatic waitCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#(driveDelay);
		end
	endtask

	task automatic runTransfer(input int run, input logic [dataWidth-1:0] base);
		expBase = base;
		fillBase = base;
		start = 1'b1;
		waitCycles(1);
		start = 1'b0;
		fillBase = '0;
		if (!busy) begin
			$display("Run %0d: busy did not rise after start", run);
			tbErrors++;
		end
		// Start while busy, must not disturb the base in use
		waitCycles(strayDelay);
		fillBase = ~base;
		start = 1'b1;
		waitCycles(1);
		start = 1'b0;
		if (!busy) begin
			$display("Run %0d: busy dropped before done", run);
			tbErrors++;
		end
		do begin
			waitCycles(1);
		end while (!done);
		// Let the checker log the finished run
		waitCycles(1);
		if (busy) begin
			$display("Run %0d: busy still high after done", run);
			tbErrors++;
		end
		if (runsDone != run + 1) begin
			$display("Run %0d: checker saw %0d completed runs", run, runsDone);
			tbErrors++;
		end
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		fillBase = '0;
		expBase = '0;
		tbErrors = 0;
		seed = seedInit;
		repeat (resetCycles) @(posedge clk);
		#(driveDelay);
		rst = 1'b0;
		waitCycles(2);
		for (int run = 0; run < runCount; run++) begin
			if (run == 0) begin
				runBase = 32'd127;
			end else begin
				runBase = $random(seed);
			end
			runTransfer(run, runBase);
		end
		waitCycles(4);
		$display("Summary: %0d runs, %0d items, %0d mismatches, %0d other errors",
			runsDone, itemCount, errorCount, tbErrors);
		if (errorCount == 0 && tbErrors == 0 && runsDone == runCount) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* verilog/memDemoPkg.sv */
//##############################
// Shared constants for the memory transfer demo
// Widths, depths, SRAM region bases and the phase codes
// Imported by every RTL block and by the testbench
//##############################

package memDemoPkg;

	// Data path
	localparam int dataWidth = 32;

	// SRAM geometry, 2048 words
	localparam int sramAdrxWidth = 11;
	localparam int sramDepth = 1 << sramAdrxWidth;

	// Register file geometry, 32 entries
	localparam int rfAdrxWidth = 5;

	// Words written by the fill phase
	localparam int fillCount = 128;

	// Block passes and words per block
	// Block size matches the register file depth
	localparam int blockCount = 4;
	localparam int blockSize = 1 << rfAdrxWidth;

	// First SRAM word of the writeback region
	localparam int writeBackBase = 512;

	// Controller phase encoding, also shown on viewPhase
	localparam int phaseWidth = 3;
	localparam logic [phaseWidth-1:0] phaseIdle = 3'd0;
	localparam logic [phaseWidth-1:0] phaseFill = 3'd1;
	localparam logic [phaseWidth-1:0] phaseLoad = 3'd2;
	localparam logic [phaseWidth-1:0] phaseReadout = 3'd3;
	localparam logic [phaseWidth-1:0] phaseDump = 3'd4;

endpackage

/* verilog/memTransferDemo.sv */
//##############################
// Top level of the memory transfer demo
// Controller between the SRAM and the register file
//##############################

`timescale 1ns/1ps

module memTransferDemo (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [memDemoPkg::dataWidth-1:0] fillBase,
	output logic busy,
	output logic done,
	output logic viewValid,
	output logic [memDemoPkg::phaseWidth-1:0] viewPhase,
	output logic [memDemoPkg::sramAdrxWidth-1:0] viewAdrx,
	output logic [memDemoPkg::dataWidth-1:0] viewData,
	output logic [memDemoPkg::dataWidth-1:0] viewMirror
);

	import memDemoPkg::*;

	// SRAM side
	logic sramWrite;
	logic [sramAdrxWidth-1:0] sramAdrx;
	logic [dataWidth-1:0] sramWrData;
	logic [dataWidth-1:0] sramRdData;

	// Register file side
	logic rfWrite;
	logic [rfAdrxWidth-1:0] rfWrAdrx;
	logic [dataWidth-1:0] rfWrData;
	logic [rfAdrxWidth-1:0] rfRdAdrx0;
	logic [rfAdrxWidth-1:0] rfRdAdrx1;
	logic [dataWidth-1:0] rfRdData0;
	logic [dataWidth-1:0] rfRdData1;

	// Sequencer, also merges the two read paths
	transferCtrl u_transferCtrl (
		.clk(clk),
		.rst(rst),
		.start(start),
		.fillBase(fillBase),
		.busy(busy),
		.done(done),
		.sramWrite(sramWrite),
		.sramAdrx(sramAdrx),
		.sramWrData(sramWrData),
		.sramRdData(sramRdData),
		.rfWrite(rfWrite),
		.rfWrAdrx(rfWrAdrx),
		.rfWrData(rfWrData),
		.rfRdAdrx0(rfRdAdrx0),
		.rfRdAdrx1(rfRdAdrx1),
		.rfRdData0(rfRdData0),
		.rfRdData1(rfRdData1),
		.viewValid(viewValid),
		.viewPhase(viewPhase),
		.viewAdrx(viewAdrx),
		.viewData(viewData),
		.viewMirror(viewMirror)
	);

	// Main storage
	sramArray u_sramArray (
		.clk(clk),
		.sramWrite(sramWrite),
		.sramAdrx(sramAdrx),
		.sramWrData(sramWrData),
		.sramRdData(sramRdData)
	);

	// Block buffer
	regFile u_regFile (
		.clk(clk),
		.rst(rst),
		.rfWrite(rfWrite),
		.rfWrAdrx(rfWrAdrx),
		.rfWrData(rfWrData),
		.rfRdAdrx0(rfRdAdrx0),
		.rfRdAdrx1(rfRdAdrx1),
		.rfRdData0(rfRdData0),
		.rfRdData1(rfRdData1)
	);

endmodule

/* verilog/regFile.sv */
//##############################
// 32-entry register file
// One synchronous write port, two combinational read ports
// Both reads return data in the same cycle as the address
//##############################

`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rst,
	input logic rfWrite,
	input logic [memDemoPkg::rfAdrxWidth-1:0] rfWrAdrx,
	input logic [memDemoPkg::dataWidth-1:0] rfWrData,
	input logic [memDemoPkg::rfAdrxWidth-1:0] rfRdAdrx0,
	input logic [memDemoPkg::rfAdrxWidth-1:0] rfRdAdrx1,
	output logic [memDemoPkg::dataWidth-1:0] rfRdData0,
	output logic [memDemoPkg::dataWidth-1:0] rfRdData1
);

	import memDemoPkg::*;

	// Register bank
	logic [dataWidth-1:0] regs [blockSize];

	// Reset clears every entry, then single-word writes
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < blockSize; i++) begin
				regs[i] <= '0;
			end
		end else if (rfWrite) begin
			regs[rfWrAdrx] <= rfWrData;
		end
	end

	// Independent read ports
	assign rfRdData0 = regs[rfRdAdrx0];
	assign rfRdData1 = regs[rfRdAdrx1];

endmodule

/* verilog/sramArray.sv */
//##############################
// Single-port synchronous SRAM model
// Write on the edge where sramWrite is high
// Otherwise the addressed word comes out one cycle later
//##############################

`timescale 1ns/1ps

module sramArray (
	input logic clk,
	input logic sramWrite,
	input logic [memDemoPkg::sramAdrxWidth-1:0] sramAdrx,
	input logic [memDemoPkg::dataWidth-1:0] sramWrData,
	output logic [memDemoPkg::dataWidth-1:0] sramRdData
);

	import memDemoPkg::*;

	// Storage array
	logic [dataWidth-1:0] mem [sramDepth];

	// One port shared by reads and writes
	// A write cycle leaves the read register unchanged
	always_ff @(posedge clk) begin
		if (sramWrite) begin
			mem[sramAdrx] <= sramWrData;
		end else begin
			// Registered read, one-cycle latency
			sramRdData <= mem[sramAdrx];
		end
	end

endmodule

/* verilog/transferCtrl.sv */
//##############################
// Phase FSM for the memory transfer demo
// Runs fill, four load and readout passes, then dump
// Drives SRAM and register file ports and the view strobe
//##############################

`timescale 1ns/1ps

module transferCtrl (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [memDemoPkg::dataWidth-1:0] fillBase,
	output logic busy,
	output logic done,
	output logic sramWrite,
	output logic [memDemoPkg::sramAdrxWidth-1:0] sramAdrx,
	output logic [memDemoPkg::dataWidth-1:0] sramWrData,
	input logic [memDemoPkg::dataWidth-1:0] sramRdData,
	output logic rfWrite,
	output logic [memDemoPkg::rfAdrxWidth-1:0] rfWrAdrx,
	output logic [memDemoPkg::dataWidth-1:0] rfWrData,
	output logic [memDemoPkg::rfAdrxWidth-1:0] rfRdAdrx0,
	output logic [memDemoPkg::rfAdrxWidth-1:0] rfRdAdrx1,
	input logic [memDemoPkg::dataWidth-1:0] rfRdData0,
	input logic [memDemoPkg::dataWidth-1:0] rfRdData1,
	output logic viewValid,
	output logic [memDemoPkg::phaseWidth-1:0] viewPhase,
	output logic [memDemoPkg::sramAdrxWidth-1:0] viewAdrx,
	output logic [memDemoPkg::dataWidth-1:0] viewData,
	output logic [memDemoPkg::dataWidth-1:0] viewMirror
);

	import memDemoPkg::*;

	// Index width for 128 words, counter has one spare bit
	// Spare bit covers the trailing cycle of load and dump
	localparam int idxWidth = $clog2(fillCount);
	localparam int blkWidth = $clog2(blockCount);

	// Terminal counts
	localparam logic [idxWidth:0] lastFill = (idxWidth + 1)'(fillCount - 1);
	localparam logic [idxWidth:0] loadEnd = (idxWidth + 1)'(blockSize);
	localparam logic [idxWidth:0] lastItem = (idxWidth + 1)'(blockSize - 1);
	localparam logic [idxWidth:0] dumpEnd = (idxWidth + 1)'(fillCount);
	localparam logic [blkWidth-1:0] lastBlock = blkWidth'(blockCount - 1);

	// Writeback region start
	localparam logic [sramAdrxWidth-1:0] wbBase = sramAdrxWidth'(writeBackBase);

	// Control state
	logic [phaseWidth-1:0] phase;
	logic [idxWidth:0] wordCnt;
	logic [blkWidth-1:0] blockCnt;

	// Fill value latched at start
	logic [dataWidth-1:0] baseReg;

	// SRAM read in flight, with its index
	logic rdPend;
	logic [idxWidth-1:0] rdAdrxQ;
	logic readIssue;

	// Address helpers
	logic [rfAdrxWidth-1:0] itemIdx;
	logic [sramAdrxWidth-1:0] passAdrx;

	// Position inside the current block
	assign itemIdx = wordCnt[rfAdrxWidth-1:0];

	// Block base plus item, used by load and writeback
	assign passAdrx = sramAdrxWidth'({blockCnt, itemIdx});

	// A read leaves the SRAM on this cycle
	assign readIssue = ((phase == phaseLoad) && (wordCnt < loadEnd)) ||
		((phase == phaseDump) && (wordCnt < dumpEnd));

	// Phase sequencing
	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= phaseIdle;
			wordCnt <= '0;
			blockCnt <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			rdPend <= 1'b0;
		end else begin
			done <= 1'b0;
			rdPend <= readIssue;
			case (phase)
				phaseIdle: begin
					// Start only takes effect from idle
					if (start) begin
						phase <= phaseFill;
						busy <= 1'b1;
						wordCnt <= '0;
						blockCnt <= '0;
					end
				end
				phaseFill: begin
					if (wordCnt == lastFill) begin
						phase <= phaseLoad;
						wordCnt <= '0;
					end else begin
						wordCnt <= wordCnt + 1'b1;
					end
				end
				phaseLoad: begin
					// 32 reads plus one cycle for the last RF write
					if (wordCnt == loadEnd) begin
						phase <= phaseReadout;
						wordCnt <= '0;
					end else begin
						wordCnt <= wordCnt + 1'b1;
					end
				end
				phaseReadout: begin
					if (wordCnt == lastItem) begin
						wordCnt <= '0;
						if (blockCnt == lastBlock) begin
							phase <= phaseDump;
						end else begin
							phase <= phaseLoad;
							blockCnt <= blockCnt + 1'b1;
						end
					end else begin
						wordCnt <= wordCnt + 1'b1;
					end
				end
				phaseDump: begin
					// Trailing cycle presents the last word
					if (wordCnt == dumpEnd) begin
						phase <= phaseIdle;
						busy <= 1'b0;
						done <= 1'b1;
						wordCnt <= '0;
					end else begin
						wordCnt <= wordCnt + 1'b1;
					end
				end
				default: begin
					phase <= phaseIdle;
				end
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if ((phase == phaseIdle) && start) begin
			baseReg <= fillBase;
		end
		// Index travels alongside the SRAM read latency
		rdAdrxQ <= wordCnt[idxWidth-1:0];
	end

	// SRAM port mux, replaces the shared bus
	always_comb begin
		sramWrite = 1'b0;
		sramAdrx = '0;
		sramWrData = '0;
		case (phase)
			phaseFill: begin
				// Descending count from the base
				sramWrite = 1'b1;
				sramAdrx = sramAdrxWidth'(wordCnt);
				sramWrData = baseReg - dataWidth'(wordCnt);
			end
			phaseLoad: begin
				sramAdrx = passAdrx;
			end
			phaseReadout: begin
				// Mirror word goes back into the writeback region
				sramWrite = 1'b1;
				sramAdrx = wbBase + passAdrx;
				sramWrData = rfRdData1;
			end
			phaseDump: begin
				sramAdrx = wbBase + sramAdrxWidth'(wordCnt[idxWidth-1:0]);
			end
			default: begin
				sramWrite = 1'b0;
			end
		endcase
	end

	// Register file write one cycle behind the load read
	assign rfWrite = rdPend && (phase == phaseLoad);
	assign rfWrAdrx = rdAdrxQ[rfAdrxWidth-1:0];
	assign rfWrData = sramRdData;

	// Port 0 walks forward, port 1 backward
	assign rfRdAdrx0 = itemIdx;
	assign rfRdAdrx1 = ~itemIdx;

	// View item mux
	always_comb begin
		viewValid = 1'b0;
		viewAdrx = '0;
		viewData = '0;
		viewMirror = '0;
		if (phase == phaseReadout) begin
			viewValid = 1'b1;
			viewAdrx = sramAdrxWidth'(itemIdx);
			viewData = rfRdData0;
			viewMirror = rfRdData1;
		end else if (phase == phaseDump) begin
			// SRAM word lines up with the delayed index
			viewValid = rdPend;
			viewAdrx = sramAdrxWidth'(rdAdrxQ);
			viewData = sramRdData;
		end
	end

	assign viewPhase = phase;

endmodule
